// File: list.f
hw/mul_pkg.sv
hw/booth_mul_core.sv
hw/result_fifo.sv
hw/result_format.sv
hw/mul_unit_top.sv
verification/mul_checker.sv
verification/tb_mul_unit.sv

// File: run.sh
#!/bin/sh
# build and run the multiply unit testbench, then scan the log for failure
rm -rf obj_dir &&
verilator --binary --timing --assert -f list.f --top-module tb_mul_unit \
	-o sim_mul_unit > build.log 2>&1 &&
./obj_dir/sim_mul_unit > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no final report in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// File: verification/tb_mul_unit.sv
`timescale 1ns/1ps

module tb_mul_unit;

	localparam int fifo_depth = 4;
	localparam int num_requests = 300;
	localparam int timeout_cycles = num_requests * 80;

	logic                      clk = 1'b0;
	logic                      rst_n;
	logic                      req_valid;
	mul_pkg::mul_op_e          req_op;
	logic [mul_pkg::xlen-1:0]  req_a;
	logic [mul_pkg::xlen-1:0]  req_b;
	logic [mul_pkg::tag_w-1:0] req_tag;
	logic                      wb_stall;
	logic                      busy;
	logic                      res_valid;
	logic [mul_pkg::xlen-1:0]  res_data;
	logic [mul_pkg::tag_w-1:0] res_tag;
	int                        data_errs;
	int                        tag_errs;
	int                        other_errs;
	int                        pending;
	logic [31:0]               lfsr;
	int                        burst;
	logic                      draining;
	int                        cycles = 0;

	always #10 clk = ~clk;

	mul_unit_top #(.fifo_depth(fifo_depth)) DUT (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op),
		.req_a(req_a), .req_b(req_b), .req_tag(req_tag), .wb_stall(wb_stall),
		.busy(busy), .res_valid(res_valid), .res_data(res_data), .res_tag(res_tag)
	);

	mul_checker #(.fifo_depth(fifo_depth)) u_check (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op),
		.req_a(req_a), .req_b(req_b), .req_tag(req_tag), .busy(busy),
		.res_valid(res_valid), .res_data(res_data), .res_tag(res_tag),
		.data_errs(data_errs), .tag_errs(tag_errs), .other_errs(other_errs),
		.pending(pending)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic get_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	// corner values mixed in with fully random ones
	task automatic pick_operand(output logic [63:0] v);
		logic [63:0] kind;
		logic [63:0] r;
		get_bits(3, kind);
		get_bits(64, r);
		case (kind[2:0])
			3'd0:    v = '0;
			3'd1:    v = '1;
			3'd2:    v = {1'b1, 63'b0};
			3'd3:    v = {60'b0, r[3:0]};	// short multiplier
			3'd4:    v = -{60'b0, r[3:0]};	// near -1
			default: v = r;
		endcase
	endtask

	// one clock edge, with the writeback stall redrawn
	task automatic tick();
		logic [63:0] r;
		@(posedge clk);
		if (draining) begin
			wb_stall <= 1'b0;
		end else if (burst > 0) begin
			wb_stall <= 1'b1;
			burst--;
		end else begin
			get_bits(8, r);
			if (r[7:0] == 8'h00)
				burst = 120;	// long stall, enough to fill the fifo
			wb_stall <= (r[1:0] == 2'b00);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("timeout: run passed %0d cycles with %0d results still missing",
				timeout_cycles, pending);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		logic [63:0] r;
		logic [63:0] a;
		logic [63:0] b;
		int          total;
		lfsr = 32'h8adba2fe;
		burst = 0;
		draining = 1'b0;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_op = mul_pkg::op_mul;
		req_a = '0;
		req_b = '0;
		req_tag = '0;
		wb_stall = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) tick();	// idle after reset
		for (int i = 0; i < num_requests; i++) begin
			pick_operand(a);
			pick_operand(b);
			get_bits(5, r);
			repeat (r[4:3]) tick();
			req_valid <= 1'b1;
			req_op <= mul_pkg::mul_op_e'(r[2:0] % 3'd5);
			req_a <= a;
			req_b <= b;
			req_tag <= mul_pkg::tag_w'(i);
			tick();
			while (busy)
				tick();
			req_valid <= 1'b0;
		end
		draining = 1'b1;
		while (pending != 0)
			tick();
		repeat (3) tick();
		total = data_errs + tag_errs + other_errs;
		$display("error counts: res_data %0d, res_tag %0d, other %0d",
			data_errs, tag_errs, other_errs);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verification/mul_checker.sv
`timescale 1ns/1ps

module mul_checker #(
	parameter int fifo_depth = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid,
	input  mul_pkg::mul_op_e          req_op,
	input  logic [mul_pkg::xlen-1:0]  req_a,
	input  logic [mul_pkg::xlen-1:0]  req_b,
	input  logic [mul_pkg::tag_w-1:0] req_tag,
	input  logic                      busy,
	input  logic                      res_valid,
	input  logic [mul_pkg::xlen-1:0]  res_data,
	input  logic [mul_pkg::tag_w-1:0] res_tag,
	output int                        data_errs,
	output int                        tag_errs,
	output int                        other_errs,
	output int                        pending
);

	logic [mul_pkg::xlen-1:0]  exp_data_q [$];
	logic [mul_pkg::tag_w-1:0] exp_tag_q [$];
	logic                      seen_req;

	// reference product from wide arithmetic, per the op's signedness
	function automatic logic [63:0] expected_result(input mul_pkg::mul_op_e op,
			input logic [63:0] a, input logic [63:0] b);
		logic         a_sext;
		logic         b_sext;
		logic [127:0] wa;
		logic [127:0] wb;
		logic [127:0] prod;
		a_sext = (op == mul_pkg::op_mulh) || (op == mul_pkg::op_mulhsu);
		b_sext = (op == mul_pkg::op_mulh);
		wa = a_sext ? {{64{a[63]}}, a} : {64'b0, a};
		wb = b_sext ? {{64{b[63]}}, b} : {64'b0, b};
		prod = wa * wb;	// modulo 2^128 keeps the low half exact for any signedness
		case (op)
			mul_pkg::op_mulh, mul_pkg::op_mulhsu, mul_pkg::op_mulhu: return prod[127:64];
			mul_pkg::op_mulw: return {{32{prod[31]}}, prod[31:0]};
			default:          return prod[63:0];
		endcase
	endfunction

	initial begin
		data_errs = 0;
		tag_errs = 0;
		other_errs = 0;
		pending = 0;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_data_q.delete();
			exp_tag_q.delete();
			seen_req = 1'b0;
			pending = 0;
		end else begin
			if (!seen_req && (busy || res_valid)) begin
				other_errs++;
				$display("%0t: busy or res_valid went high before the first request", $time);
			end
			if (res_valid) begin
				if (exp_data_q.size() == 0) begin
					other_errs++;
					$display("%0t: result with tag %h arrived with no request outstanding",
						$time, res_tag);
				end else begin
					if (res_data !== exp_data_q[0]) begin
						data_errs++;
						$display("[ERROR] %0t res_data expected %h got %h",
							$time, exp_data_q[0], res_data);
					end
					if (res_tag !== exp_tag_q[0]) begin
						tag_errs++;
						$display("[ERROR] %0t res_tag expected %h got %h",
							$time, exp_tag_q[0], res_tag);
					end
					void'(exp_data_q.pop_front());
					void'(exp_tag_q.pop_front());
				end
			end
			if (req_valid && !busy) begin	// acceptance
				exp_data_q.push_back(expected_result(req_op, req_a, req_b));
				exp_tag_q.push_back(req_tag);
				seen_req = 1'b1;
			end
			// fifo plus one result register is all the unit can hold
			if (exp_data_q.size() > fifo_depth + 1) begin
				other_errs++;
				$display("%0t: %0d results in flight, more than the unit can hold",
					$time, exp_data_q.size());
			end
			pending = exp_data_q.size();
		end
	end

endmodule

// File: hw/mul_unit_top.sv
`timescale 1ns/1ps

module mul_unit_top #(
	parameter int fifo_depth = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid,
	input  mul_pkg::mul_op_e          req_op,
	input  logic [mul_pkg::xlen-1:0]  req_a,
	input  logic [mul_pkg::xlen-1:0]  req_b,
	input  logic [mul_pkg::tag_w-1:0] req_tag,
	input  logic                      wb_stall,
	output logic                      busy,
	output logic                      res_valid,
	output logic [mul_pkg::xlen-1:0]  res_data,
	output logic [mul_pkg::tag_w-1:0] res_tag
);

	logic                push_valid;
	mul_pkg::mul_entry_t push_entry;
	logic                fifo_full;
	logic                fifo_empty;
	mul_pkg::mul_entry_t head_entry;
	logic                pop;

	booth_mul_core u_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_a      (req_a),
		.req_b      (req_b),
		.req_tag    (req_tag),
		.fifo_full  (fifo_full),
		.busy       (busy),
		.push_valid (push_valid),
		.push_entry (push_entry)
	);

	// finished products wait here while writeback stalls
	result_fifo #(
		.fifo_depth (fifo_depth),
		.payload_t  (mul_pkg::mul_entry_t)
	) u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_valid (push_valid),
		.push_entry (push_entry),
		.pop        (pop),
		.head_entry (head_entry),
		.empty      (fifo_empty),
		.full       (fifo_full)
	);

	result_format u_format (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_stall   (wb_stall),
		.empty      (fifo_empty),
		.head_entry (head_entry),
		.pop        (pop),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.res_tag    (res_tag)
	);

endmodule

// File: hw/result_format.sv
`timescale 1ns/1ps

module result_format (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wb_stall,
	input  logic                      empty,
	input  mul_pkg::mul_entry_t       head_entry,
	output logic                      pop,
	output logic                      res_valid,
	output logic [mul_pkg::xlen-1:0]  res_data,
	output logic [mul_pkg::tag_w-1:0] res_tag
);

	logic [mul_pkg::xlen-1:0] sel_data;

	assign pop = ~empty & ~wb_stall;

	always_comb begin
		case (head_entry.op)
			mul_pkg::op_mulh,
			mul_pkg::op_mulhsu,
			mul_pkg::op_mulhu: sel_data = head_entry.prod[2*mul_pkg::xlen-1:mul_pkg::xlen];
			mul_pkg::op_mulw:  sel_data = {{32{head_entry.prod[31]}}, head_entry.prod[31:0]};
			default:           sel_data = head_entry.prod[mul_pkg::xlen-1:0];
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= pop;	// one pulse per popped entry
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			res_data <= sel_data;
			res_tag <= head_entry.tag;
		end
	end

	// a popped head always holds a written entry
	assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !$isunknown(head_entry));

endmodule

// File: hw/result_fifo.sv
`timescale 1ns/1ps

module result_fifo #(
	parameter int  fifo_depth = 4,
	parameter type payload_t  = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push_valid,
	input  payload_t push_entry,
	input  logic     pop,
	output payload_t head_entry,
	output logic     empty,
	output logic     full
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	payload_t         mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_push;
	logic             do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(fifo_depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == cnt_w'(fifo_depth));
	assign do_push = push_valid & ~full;
	assign do_pop = pop & ~empty;
	assign head_entry = mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		push_valid |-> !full);

	assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

// File: hw/booth_mul_core.sv
`timescale 1ns/1ps

module booth_mul_core (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid,
	input  mul_pkg::mul_op_e          req_op,
	input  logic [mul_pkg::xlen-1:0]  req_a,
	input  logic [mul_pkg::xlen-1:0]  req_b,
	input  logic [mul_pkg::tag_w-1:0] req_tag,
	input  logic                      fifo_full,
	output logic                      busy,
	output logic                      push_valid,
	output mul_pkg::mul_entry_t       push_entry
);

	localparam int acc_w = 2 * mul_pkg::booth_w;

	logic                         active;
	logic                         accept;
	logic                         a_signed;
	logic                         b_signed;
	logic [mul_pkg::booth_w-1:0]  a_ext;
	logic [mul_pkg::booth_w-1:0]  b_ext;
	logic [acc_w-1:0]             mcand;
	logic [mul_pkg::booth_w-1:0]  mplier;
	logic                         mplier_lsb;
	logic [acc_w-1:0]             acc;
	logic [2:0]                   booth_win;
	logic [acc_w-1:0]             booth_term;
	logic [mul_pkg::booth_w-1:0]  mplier_nxt;
	logic [acc_w-1:0]             acc_nxt;
	logic                         last_step;
	mul_pkg::mul_op_e             op_q;
	logic [mul_pkg::tag_w-1:0]    tag_q;

	// push cycle counts as busy so the fifo slot is settled before next accept
	assign busy = active | push_valid | fifo_full;
	assign accept = req_valid & ~busy;

	// only the high-half ops care about signedness
	assign a_signed = (req_op != mul_pkg::op_mulhu);
	assign b_signed = (req_op != mul_pkg::op_mulhu) && (req_op != mul_pkg::op_mulhsu);

	assign a_ext = {{2{a_signed & req_a[mul_pkg::xlen-1]}}, req_a};
	assign b_ext = {{2{b_signed & req_b[mul_pkg::xlen-1]}}, req_b};

	assign booth_win = {mplier[1:0], mplier_lsb};

	always_comb begin
		case (booth_win)
			3'b001, 3'b010: booth_term = mcand;
			3'b011:         booth_term = mcand << 1;
			3'b100:         booth_term = -(mcand << 1);
			3'b101, 3'b110: booth_term = -mcand;
			default:        booth_term = '0;	// 000 / 111
		endcase
	end

	assign acc_nxt = acc + booth_term;
	assign mplier_nxt = $signed(mplier) >>> 2;

	// remaining windows would all be 000 or 111
	assign last_step = active & (mplier_nxt == {mul_pkg::booth_w{mplier[1]}});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			push_valid <= 1'b0;
		end else begin
			push_valid <= last_step;
			if (accept)
				active <= 1'b1;
			else if (last_step)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			mcand <= {{mul_pkg::booth_w{a_ext[mul_pkg::booth_w-1]}}, a_ext};
			mplier <= b_ext;
			mplier_lsb <= 1'b0;	// implicit y[-1]
			acc <= '0;
			op_q <= req_op;
			tag_q <= req_tag;
		end else if (active) begin
			mcand <= mcand << 2;
			mplier <= mplier_nxt;
			mplier_lsb <= mplier[1];
			acc <= acc_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (last_step) begin
			push_entry.prod <= acc_nxt[2*mul_pkg::xlen-1:0];
			push_entry.op <= op_q;
			push_entry.tag <= tag_q;
		end
	end

	// an in-flight product always has a free fifo slot waiting
	assert property (@(posedge clk) disable iff (!rst_n)
		active |-> !fifo_full);

	// space was reserved at acceptance
	assert property (@(posedge clk) disable iff (!rst_n)
		push_valid |-> !fifo_full);

endmodule

// File: hw/mul_pkg.sv
package mul_pkg;

	localparam int xlen = 64;
	localparam int booth_w = xlen + 2;	// room for sign/zero extension
	localparam int tag_w = 4;

	typedef enum logic [2:0] {
		op_mul,
		op_mulh,
		op_mulhsu,
		op_mulhu,
		op_mulw
	} mul_op_e;

	// one finished product waiting for writeback
	typedef struct packed {
		logic [2*xlen-1:0] prod;
		mul_op_e op;
		logic [tag_w-1:0] tag;
	} mul_entry_t;

endpackage
